/* rv_isa_pkg.sv */
// RV32I definitions shared by the execute and memory stages.
// Holds widths, memory sizing and the encodings for ALU ops,
// access sizes and load/store func3 codes.
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int DMEM_WORDS = 256;        // 1 KiB of data memory
    localparam int DMEM_AW    = 8;          // Word index width
    localparam int BYTE_LANES = XLEN / 8;

    // Bit of func3 that marks an unsigned load
    localparam int F3_UNSIGNED_BIT = 2;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } data_size_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } mem_func3_e;

    // Store codes share their values with the signed loads
    localparam mem_func3_e F3_SB = F3_LB;
    localparam mem_func3_e F3_SH = F3_LH;
    localparam mem_func3_e F3_SW = F3_LW;

endpackage

/* pipe_pkg.sv */
// Bundles passed between the pipeline stages.
// id_ex_t enters the execute stage, ex_mem_t sits in the EX/MEM
// register and wb_t leaves the memory stage toward writeback.
package pipe_pkg;

    // Decoded instruction from the upstream ID/EX register
    typedef struct packed {
        logic                           reg_write;
        logic                           mem_read;
        logic                           mem_write;
        logic                           mem_to_reg;
        rv_isa_pkg::data_size_e         data_size;
        rv_isa_pkg::mem_func3_e         func3;
        rv_isa_pkg::alu_op_e            alu_op;
        logic [rv_isa_pkg::XLEN-1:0]    op_a;       // Operands already selected
        logic [rv_isa_pkg::XLEN-1:0]    op_b;
        logic [rv_isa_pkg::XLEN-1:0]    store_data;
        logic [rv_isa_pkg::REG_AW-1:0]  rd_addr;
    } id_ex_t;

    // Contents of the EX/MEM register
    typedef struct packed {
        logic                           reg_write;
        logic                           mem_read;
        logic                           mem_write;
        logic                           mem_to_reg;
        rv_isa_pkg::data_size_e         data_size;
        rv_isa_pkg::mem_func3_e         func3;
        logic [rv_isa_pkg::XLEN-1:0]    alu_result; // Also the memory address
        logic [rv_isa_pkg::XLEN-1:0]    store_data;
        logic [rv_isa_pkg::REG_AW-1:0]  rd_addr;
    } ex_mem_t;

    // Writeback bundle for the register file
    typedef struct packed {
        logic                           reg_write;
        logic [rv_isa_pkg::REG_AW-1:0]  rd_addr;
        logic [rv_isa_pkg::XLEN-1:0]    wb_data;
    } wb_t;

endpackage

/* alu.sv */
// Integer ALU for the execute stage.
// Purely combinational; the op selects one RV32I arithmetic,
// logic, shift or compare result.
`timescale 1ns/100ps

module alu (
    input  rv_isa_pkg::alu_op_e             i_op,
    input  logic [rv_isa_pkg::XLEN-1:0]     i_a,
    input  logic [rv_isa_pkg::XLEN-1:0]     i_b,
    output logic [rv_isa_pkg::XLEN-1:0]     o_result
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];    // Only the low five bits shift

    always_comb begin
        case (i_op)
            rv_isa_pkg::ALU_ADD: begin
                o_result = i_a + i_b;
            end
            rv_isa_pkg::ALU_SUB: begin
                o_result = i_a - i_b;
            end
            rv_isa_pkg::ALU_AND: begin
                o_result = i_a & i_b;
            end
            rv_isa_pkg::ALU_OR: begin
                o_result = i_a | i_b;
            end
            rv_isa_pkg::ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            rv_isa_pkg::ALU_SLL: begin
                o_result = i_a << shamt;
            end
            rv_isa_pkg::ALU_SRL: begin
                o_result = i_a >> shamt;
            end
            rv_isa_pkg::ALU_SRA: begin
                o_result = $unsigned($signed(i_a) >>> shamt);
            end
            rv_isa_pkg::ALU_SLT: begin
                // Set-less-than returns 0 or 1
                o_result = {{(rv_isa_pkg::XLEN-1){1'b0}},
                            ($signed(i_a) < $signed(i_b))};
            end
            rv_isa_pkg::ALU_SLTU: begin
                o_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, (i_a < i_b)};
            end
            default: begin
                o_result = '0;  // Unused encodings
            end
        endcase
    end

endmodule

/* ex_mem_reg.sv */
// EX/MEM pipeline register.
// Loads the execute result when enabled, holds otherwise, and
// turns into a bubble on flush regardless of the enable.
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_en,       // Advance the pipeline
    input  logic                i_flush,    // Insert a bubble
    input  pipe_pkg::ex_mem_t   i_ex,
    output pipe_pkg::ex_mem_t   o_mem
);

    // A bubble has every field zero, so it can neither store nor write back
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem <= '0;
        end else if (i_flush) begin
            o_mem <= '0;
        end else if (i_en) begin
            o_mem <= i_ex;
        end
    end

endmodule

/* data_mem_stage.sv */
// Memory-access stage with word-organized data memory.
// Stores write byte lanes, loads read synchronously and the read word
// is registered with its attributes; extension and the writeback mux
// act on the registered values, so o_wb moves only on clock edges.
`timescale 1ns/100ps

module data_mem_stage (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_en,
    input  pipe_pkg::ex_mem_t   i_mem,
    output pipe_pkg::wb_t       o_wb
);

    logic [rv_isa_pkg::XLEN-1:0]        mem [rv_isa_pkg::DMEM_WORDS];

    logic [rv_isa_pkg::DMEM_AW-1:0]     word_idx;
    logic [1:0]                         lane;
    logic [rv_isa_pkg::BYTE_LANES-1:0]  byte_en;
    logic [rv_isa_pkg::XLEN-1:0]        wr_data;

    logic [rv_isa_pkg::XLEN-1:0]        rd_word_q;
    logic [1:0]                         lane_q;
    rv_isa_pkg::data_size_e             size_q;
    logic                               unsigned_q;
    logic                               mem_to_reg_q;
    logic                               reg_write_q;
    logic [rv_isa_pkg::REG_AW-1:0]      rd_addr_q;
    logic [rv_isa_pkg::XLEN-1:0]        alu_q;

    logic [7:0]                         ld_byte;
    logic [15:0]                        ld_half;
    logic [rv_isa_pkg::XLEN-1:0]        ld_data;

    assign word_idx = i_mem.alu_result[rv_isa_pkg::DMEM_AW+1:2];
    assign lane     = i_mem.alu_result[1:0];

    // Lane enables and store data replicated into every lane position
    always_comb begin
        case (i_mem.data_size)
            rv_isa_pkg::SIZE_BYTE: begin
                byte_en = 4'b0001 << lane;
                wr_data = {4{i_mem.store_data[7:0]}};
            end
            rv_isa_pkg::SIZE_HALF: begin
                byte_en = lane[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{i_mem.store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_data = i_mem.store_data;
            end
        endcase
    end

    // Memory array and read port; a same-word store returns old data
    always_ff @(posedge clk) begin
        if (i_en && i_mem.mem_write) begin
            for (int b = 0; b < rv_isa_pkg::BYTE_LANES; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
        if (i_en && i_mem.mem_read) begin
            rd_word_q <= mem[word_idx];
        end
    end

    // Access attributes follow the read word into the next cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lane_q       <= '0;
            size_q       <= rv_isa_pkg::SIZE_BYTE;
            unsigned_q   <= 1'b0;
            mem_to_reg_q <= 1'b0;
            reg_write_q  <= 1'b0;
            rd_addr_q    <= '0;
            alu_q        <= '0;
        end else if (i_en) begin
            lane_q       <= lane;
            size_q       <= i_mem.data_size;
            unsigned_q   <= i_mem.func3[rv_isa_pkg::F3_UNSIGNED_BIT];
            mem_to_reg_q <= i_mem.mem_to_reg;
            reg_write_q  <= i_mem.reg_write;
            rd_addr_q    <= i_mem.rd_addr;
            alu_q        <= i_mem.alu_result;
        end
    end

    assign ld_byte = rd_word_q[lane_q*8 +: 8];
    assign ld_half = lane_q[1] ? rd_word_q[31:16] : rd_word_q[15:0];

    always_comb begin
        case (size_q)
            rv_isa_pkg::SIZE_BYTE: begin
                ld_data = {{24{ld_byte[7] & ~unsigned_q}}, ld_byte};
            end
            rv_isa_pkg::SIZE_HALF: begin
                ld_data = {{16{ld_half[15] & ~unsigned_q}}, ld_half};
            end
            default: begin
                ld_data = rd_word_q;
            end
        endcase
    end

    assign o_wb.reg_write = reg_write_q;
    assign o_wb.rd_addr   = rd_addr_q;
    assign o_wb.wb_data   = mem_to_reg_q ? ld_data : alu_q;

endmodule

/* exec_mem_top.sv */
// Back half of the RV32I pipeline: execute, EX/MEM and memory access.
// Takes a decoded bundle each enabled cycle and returns its writeback
// bundle two enabled edges after capture.
`timescale 1ns/100ps

module exec_mem_top (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_en,
    input  logic                i_flush,
    input  pipe_pkg::id_ex_t    i_id_ex,
    output pipe_pkg::wb_t       o_wb
);

    logic [rv_isa_pkg::XLEN-1:0]    alu_result;
    pipe_pkg::ex_mem_t              ex_d;
    pipe_pkg::ex_mem_t              ex_mem_q;

    alu alu_inst (
        .i_op     (i_id_ex.alu_op),
        .i_a      (i_id_ex.op_a),
        .i_b      (i_id_ex.op_b),
        .o_result (alu_result)
    );

    // Control passes straight through execute next to the ALU result
    assign ex_d.reg_write  = i_id_ex.reg_write;
    assign ex_d.mem_read   = i_id_ex.mem_read;
    assign ex_d.mem_write  = i_id_ex.mem_write;
    assign ex_d.mem_to_reg = i_id_ex.mem_to_reg;
    assign ex_d.data_size  = i_id_ex.data_size;
    assign ex_d.func3      = i_id_ex.func3;
    assign ex_d.alu_result = alu_result;
    assign ex_d.store_data = i_id_ex.store_data;
    assign ex_d.rd_addr    = i_id_ex.rd_addr;

    ex_mem_reg ex_mem_reg_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_en    (i_en),
        .i_flush (i_flush),
        .i_ex    (ex_d),
        .o_mem   (ex_mem_q)
    );

    data_mem_stage data_mem_stage_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_en    (i_en),
        .i_mem   (ex_mem_q),
        .o_wb    (o_wb)
    );

endmodule

/* tb_exec_mem.sv */
// Self-checking testbench for exec_mem_top.
// A model tracks the instruction held in EX/MEM and a shadow data memory,
// and assertions compare o_wb with the model on every falling edge.
// Covers reset, random ALU ops, word and narrow accesses, flush and stall.
`timescale 1ns/100ps

module tb_exec_mem;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ALU    = 200;
    localparam int NUM_MIX    = 40;
    localparam int NUM_INSTR  = NUM_ALU + NUM_MIX + 60;    // Directed steps need under 60
    localparam logic [31:0] WIN_BASE = 32'h40;              // Eight-word window for the mix
    localparam pipe_pkg::id_ex_t NOP = '0;

    logic               clk;
    logic               i_rst_n;
    logic               i_en;
    logic               i_flush;
    pipe_pkg::id_ex_t   i_id_ex;
    pipe_pkg::wb_t      o_wb;

    pipe_pkg::id_ex_t   pending[$];     // Instruction sitting in EX/MEM
    pipe_pkg::wb_t      exp_wb;
    logic [31:0]        shadow [rv_isa_pkg::DMEM_WORDS];
    integer             seed = 38;
    int                 errors = 0;
    int                 checks = 0;

    exec_mem_top exec_mem_top_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_en    (i_en),
        .i_flush (i_flush),
        .i_id_ex (i_id_ex),
        .o_wb    (o_wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] alu_model(input rv_isa_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            rv_isa_pkg::ALU_ADD:  return a + b;
            rv_isa_pkg::ALU_SUB:  return a - b;
            rv_isa_pkg::ALU_AND:  return a & b;
            rv_isa_pkg::ALU_OR:   return a | b;
            rv_isa_pkg::ALU_XOR:  return a ^ b;
            rv_isa_pkg::ALU_SLL:  return a << sh;
            rv_isa_pkg::ALU_SRL:  return a >> sh;
            rv_isa_pkg::ALU_SRA:  return 32'({{32{a[31]}}, a} >> sh);  // Sign copies shift in
            rv_isa_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:              return 32'd0;
        endcase
    endfunction

    // Picks the byte or half at the offset and extends it
    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] off,
                                               input rv_isa_pkg::data_size_e size,
                                               input logic uns);
        logic [31:0] shifted;
        logic [7:0]  b;
        logic [15:0] h;
        shifted = word >> (8 * off);
        b = shifted[7:0];
        h = shifted[15:0];
        case (size)
            rv_isa_pkg::SIZE_BYTE: return uns ? {24'd0, b} : {{24{b[7]}}, b};
            rv_isa_pkg::SIZE_HALF: return uns ? {16'd0, h} : {{16{h[15]}}, h};
            default:               return word;
        endcase
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] pick_rd();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic pipe_pkg::id_ex_t alu_instr(input rv_isa_pkg::alu_op_e op,
                                                  input logic [31:0] a, input logic [31:0] b,
                                                  input logic [4:0] rd);
        pipe_pkg::id_ex_t ins;
        ins = '0;
        ins.reg_write = 1'b1;
        ins.data_size = rv_isa_pkg::SIZE_WORD;
        ins.func3     = rv_isa_pkg::F3_LW;
        ins.alu_op    = op;
        ins.op_a      = a;
        ins.op_b      = b;
        ins.rd_addr   = rd;
        return ins;
    endfunction

    function automatic pipe_pkg::id_ex_t store_instr(input logic [31:0] addr,
                                                    input logic [31:0] data,
                                                    input rv_isa_pkg::data_size_e size);
        pipe_pkg::id_ex_t ins;
        ins = '0;
        ins.mem_write  = 1'b1;
        ins.data_size  = size;
        ins.alu_op     = rv_isa_pkg::ALU_ADD;   // Address is op_a + 0
        ins.op_a       = addr;
        ins.store_data = data;
        case (size)
            rv_isa_pkg::SIZE_BYTE: ins.func3 = rv_isa_pkg::F3_SB;
            rv_isa_pkg::SIZE_HALF: ins.func3 = rv_isa_pkg::F3_SH;
            default:               ins.func3 = rv_isa_pkg::F3_SW;
        endcase
        return ins;
    endfunction

    function automatic pipe_pkg::id_ex_t load_instr(input logic [31:0] addr,
                                                   input rv_isa_pkg::mem_func3_e f3,
                                                   input logic [4:0] rd);
        pipe_pkg::id_ex_t ins;
        ins = '0;
        ins.reg_write  = 1'b1;
        ins.mem_read   = 1'b1;
        ins.mem_to_reg = 1'b1;
        ins.func3      = f3;
        ins.alu_op     = rv_isa_pkg::ALU_ADD;
        ins.op_a       = addr;
        ins.rd_addr    = rd;
        case (f3)
            rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LBU: ins.data_size = rv_isa_pkg::SIZE_BYTE;
            rv_isa_pkg::F3_LH, rv_isa_pkg::F3_LHU: ins.data_size = rv_isa_pkg::SIZE_HALF;
            default:                               ins.data_size = rv_isa_pkg::SIZE_WORD;
        endcase
        return ins;
    endfunction

    // Random bits on every field for cycles where nothing is captured
    function automatic pipe_pkg::id_ex_t junk_instr();
        logic [127:0] bits;
        bits = {rand_word(), rand_word(), rand_word(), rand_word()};
        return pipe_pkg::id_ex_t'(bits[$bits(pipe_pkg::id_ex_t)-1:0]);
    endfunction

    task automatic issue(input pipe_pkg::id_ex_t ins, input logic en, input logic flush);
        @(negedge clk);
        i_id_ex = ins;
        i_en    = en;
        i_flush = flush;
    endtask

    // Expected bundle and shadow memory update as an instruction leaves the memory stage
    task automatic retire(input pipe_pkg::id_ex_t ins);
        logic [31:0] addr;
        logic [7:0]  idx;
        addr = alu_model(ins.alu_op, ins.op_a, ins.op_b);
        idx  = addr[9:2];
        exp_wb.reg_write = ins.reg_write;
        exp_wb.rd_addr   = ins.rd_addr;
        if (ins.mem_to_reg) begin
            exp_wb.wb_data = load_value(shadow[idx], addr[1:0], ins.data_size, ins.func3[2]);
        end else begin
            exp_wb.wb_data = addr;
        end
        if (ins.mem_write) begin
            case (ins.data_size)
                rv_isa_pkg::SIZE_BYTE: shadow[idx][addr[1:0]*8 +: 8] = ins.store_data[7:0];
                rv_isa_pkg::SIZE_HALF: shadow[idx][addr[1]*16 +: 16] = ins.store_data[15:0];
                default:               shadow[idx] = ins.store_data;
            endcase
        end
    endtask

    // Pipeline model; an empty queue stands for a bubble
    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending.delete();
            exp_wb = '0;
        end else begin
            if (i_en) begin
                if (pending.size() != 0) begin
                    retire(pending.pop_front());
                end else begin
                    exp_wb = '0;
                end
            end
            if (i_flush) begin
                pending.delete();
            end else if (i_en) begin
                pending.push_back(i_id_ex);
            end
        end
    end

    always @(negedge clk) begin
        checks++;
        assert (o_wb.reg_write === exp_wb.reg_write) else begin
            errors++;
            $display("Mismatch at %0t: reg_write got %b expected %b",
                     $time, o_wb.reg_write, exp_wb.reg_write);
        end
        assert (o_wb.rd_addr === exp_wb.rd_addr) else begin
            errors++;
            $display("Mismatch at %0t: rd_addr got %0d expected %0d",
                     $time, o_wb.rd_addr, exp_wb.rd_addr);
        end
        assert (o_wb.wb_data === exp_wb.wb_data) else begin
            errors++;
            $display("Mismatch at %0t: wb_data got %h expected %h",
                     $time, o_wb.wb_data, exp_wb.wb_data);
        end
    end

    reset_quiet: assert property (@(negedge clk) !i_rst_n |-> !o_wb.reg_write) else begin
        errors++;
        $display("Mismatch at %0t: reg_write high during reset", $time);
    end

    stall_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
                                 !$past(i_en) |-> $stable(o_wb)) else begin
        errors++;
        $display("Mismatch at %0t: o_wb changed while i_en was low", $time);
    end

    task automatic random_alu_ops();
        int op;
        for (int n = 0; n < NUM_ALU; n++) begin
            op = $unsigned($random(seed)) % 10;
            issue(alu_instr(rv_isa_pkg::alu_op_e'(op[3:0]), rand_word(), rand_word(), pick_rd()),
                  1'b1, 1'b0);
        end
    endtask

    task automatic word_accesses();
        int          k;
        logic [31:0] r;
        for (int w = 0; w < 8; w++) begin
            issue(store_instr(WIN_BASE + w*4, rand_word(), rv_isa_pkg::SIZE_WORD), 1'b1, 1'b0);
        end
        issue(store_instr(WIN_BASE + 8, 32'ha5c3_0f96, rv_isa_pkg::SIZE_WORD), 1'b1, 1'b0);
        issue(load_instr(WIN_BASE + 8, rv_isa_pkg::F3_LW, 5'd3), 1'b1, 1'b0);
        for (int n = 0; n < NUM_MIX; n++) begin
            k = $unsigned($random(seed)) % 8;
            r = rand_word();
            if (r[0]) begin
                issue(store_instr(WIN_BASE + k*4, rand_word(), rv_isa_pkg::SIZE_WORD), 1'b1, 1'b0);
            end else begin
                issue(load_instr(WIN_BASE + k*4, rv_isa_pkg::F3_LW, pick_rd()), 1'b1, 1'b0);
            end
        end
    endtask

    task automatic narrow_accesses();
        logic [31:0] data;
        issue(store_instr(32'h60, 32'h1122_3344, rv_isa_pkg::SIZE_WORD), 1'b1, 1'b0);
        for (int lane = 0; lane < 4; lane++) begin
            data = rand_word();
            data[7] = (lane % 2 == 0);      // Even lanes get a negative byte
            issue(store_instr(32'h60 + lane, data, rv_isa_pkg::SIZE_BYTE), 1'b1, 1'b0);
            issue(load_instr(32'h60, rv_isa_pkg::F3_LW, 5'd1), 1'b1, 1'b0);
        end
        for (int lane = 0; lane < 4; lane++) begin
            issue(load_instr(32'h60 + lane, rv_isa_pkg::F3_LB, 5'd2), 1'b1, 1'b0);
            issue(load_instr(32'h60 + lane, rv_isa_pkg::F3_LBU, 5'd3), 1'b1, 1'b0);
        end
        issue(store_instr(32'h64, rand_word(), rv_isa_pkg::SIZE_WORD), 1'b1, 1'b0);
        issue(store_instr(32'h64, 32'h0000_8a5c, rv_isa_pkg::SIZE_HALF), 1'b1, 1'b0);
        issue(load_instr(32'h64, rv_isa_pkg::F3_LW, 5'd4), 1'b1, 1'b0);
        issue(store_instr(32'h66, 32'hffff_3c7e, rv_isa_pkg::SIZE_HALF), 1'b1, 1'b0);
        issue(load_instr(32'h64, rv_isa_pkg::F3_LW, 5'd4), 1'b1, 1'b0);
        issue(load_instr(32'h64, rv_isa_pkg::F3_LH, 5'd5), 1'b1, 1'b0);
        issue(load_instr(32'h64, rv_isa_pkg::F3_LHU, 5'd6), 1'b1, 1'b0);
        issue(load_instr(32'h66, rv_isa_pkg::F3_LH, 5'd7), 1'b1, 1'b0);
        issue(load_instr(32'h66, rv_isa_pkg::F3_LHU, 5'd8), 1'b1, 1'b0);
    endtask

    task automatic flush_cases();
        issue(store_instr(32'h70, 32'h0bad_f00d, rv_isa_pkg::SIZE_WORD), 1'b1, 1'b0);
        issue(alu_instr(rv_isa_pkg::ALU_ADD, 32'd7, 32'd9, 5'd5), 1'b1, 1'b1);
        issue(store_instr(32'h70, 32'hdead_beef, rv_isa_pkg::SIZE_WORD), 1'b1, 1'b1);
        issue(load_instr(32'h70, rv_isa_pkg::F3_LW, 5'd7), 1'b1, 1'b0);
        issue(alu_instr(rv_isa_pkg::ALU_XOR, rand_word(), rand_word(), 5'd9), 1'b1, 1'b0);
        issue(junk_instr(), 1'b0, 1'b1);    // Kills the held instruction while stalled
    endtask

    task automatic stall_cases();
        issue(alu_instr(rv_isa_pkg::ALU_SUB, rand_word(), rand_word(), 5'd10), 1'b1, 1'b0);
        issue(store_instr(32'h74, rand_word(), rv_isa_pkg::SIZE_WORD), 1'b1, 1'b0);
        repeat (4) issue(junk_instr(), 1'b0, 1'b0);
        issue(load_instr(32'h74, rv_isa_pkg::F3_LW, 5'd11), 1'b1, 1'b0);
        issue(alu_instr(rv_isa_pkg::ALU_SRA, rand_word(), rand_word(), 5'd12), 1'b1, 1'b0);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_en    = 1'b0;
        i_flush = 1'b0;
        i_id_ex = '0;
        repeat (2) @(negedge clk);
        i_rst_n = 1'b1;
        random_alu_ops();
        word_accesses();
        narrow_accesses();
        flush_cases();
        stall_cases();
        repeat (3) issue(NOP, 1'b1, 1'b0);  // Drain the pipeline
        @(negedge clk);
        #(CLK_PERIOD/4);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (NUM_INSTR + 20));
        $display("Timeout: the run did not finish within %0d cycles", NUM_INSTR + 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* list.f */
rv_isa_pkg.sv
pipe_pkg.sv
alu.sv
ex_mem_reg.sv
data_mem_stage.sv
exec_mem_top.sv
tb_exec_mem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
# Run from the project root.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --assert -f list.f --top-module tb_exec_mem \
    -Mdir obj_dir -o sim_exec_mem > build.log 2>&1 \
    && ./obj_dir/sim_exec_mem > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qxF '** PASS **' sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
